// ==== source/cpuIsaPkg.sv ====
// instruction set of the 8-bit core, imported by the decoder, datapath and testbench
`default_nettype none

package cpuIsaPkg;

  ////////////////////
  // instruction word
  ////////////////////

  // full instruction width as seen on the program memory port
  localparam int instrWidth = 12;

  // sixteen opcodes, upper nibble of the instruction
  typedef enum logic [3:0] {
    opMov, opAnd, opOr, opXor,
    opAdd, opAdds, opSub, opSubs,
    opShift, opLi, opSlt, opEq,
    opBos, opBns, opJ, opDelay
  } opcodeE;

  // register number, four bits for sixteen registers
  typedef logic [3:0] regIndexT;

  // regA and regB together also carry the 8-bit immediate
  typedef struct packed {
    opcodeE   opcode;
    regIndexT regA;
    regIndexT regB;
  } instructionT;

  ////////////////////
  // special registers
  ////////////////////

  // read-only constants
  localparam regIndexT regZero    = 4'd0;
  localparam regIndexT regOne     = 4'd1;
  // button latch, cleared when read
  localparam regIndexT regPortIn  = 4'd2;
  // loaded from the random input every cycle
  localparam regIndexT regRand    = 4'd3;
  localparam regIndexT regPortOut = 4'd4;
  // li target
  localparam regIndexT regImm     = 4'd5;
  // alu result target
  localparam regIndexT regResult  = 4'd6;

endpackage

`default_nettype wire

// ==== source/cpuDatapathPkg.sv ====
// datapath widths and the control bundle shared by the decoder and the execution blocks
`default_nettype none

package cpuDatapathPkg;

  // data word and program address share one width
  localparam int dataWidth = 8;

  typedef logic [dataWidth-1:0] dataT;
  typedef logic [dataWidth-1:0] pcT;

  // delay length is the operand times four
  localparam int delayShift = 2;

  // wide enough for the largest operand after the shift
  typedef logic [dataWidth+delayShift-1:0] delayCountT;

  // write address rule when the immediate rule is not in use
  typedef enum logic {
    wsResult,
    wsRegA
  } writeSelectE;

  // decoder output, one set per instruction
  // writeImmediate also picks the imm register as write target
  typedef struct packed {
    logic        writeEnable;
    logic        writeImmediate;
    logic        pcJump;
    logic        pcDelay;
    writeSelectE writeSelect;
  } cpuCtrlT;

endpackage

`default_nettype wire

// ==== source/cpuDecoder.sv ====
// combinational instruction decoder, turns opcode and set flag into the control bundle
`timescale 1ns/1ps
`default_nettype none

module cpuDecoder (
  input  cpuIsaPkg::instructionT instruction,
  input  logic                   set,
  output cpuDatapathPkg::cpuCtrlT ctrl
);

  import cpuIsaPkg::*;
  import cpuDatapathPkg::*;

  always_comb begin
    // default is an instruction with no side effects
    ctrl = '{
      writeEnable:    1'b0,
      writeImmediate: 1'b0,
      pcJump:         1'b0,
      pcDelay:        1'b0,
      writeSelect:    wsResult
    };

    unique case (instruction.opcode)
      // writes back into the register named by regA
      opMov, opAdds, opSubs: begin
        ctrl.writeEnable = 1'b1;
        ctrl.writeSelect = wsRegA;
      end
      // plain alu ops land in the result register
      opAnd, opOr, opXor, opAdd, opSub, opShift: begin
        ctrl.writeEnable = 1'b1;
      end
      // immediate goes to the imm register
      opLi: begin
        ctrl.writeEnable    = 1'b1;
        ctrl.writeImmediate = 1'b1;
      end
      // branch on flag
      opBos: ctrl.pcJump = set;
      opBns: ctrl.pcJump = ~set;
      opJ:   ctrl.pcJump = 1'b1;
      opDelay: ctrl.pcDelay = 1'b1;
      // slt and eq only touch the flag inside the alu
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
// sixteen 8-bit registers with constant, button, random and port registers mapped in
`timescale 1ns/1ps
`default_nettype none

module registerFile (
  input  logic                    clk,
  input  logic                    reset,
  input  cpuIsaPkg::instructionT  instruction,
  input  cpuDatapathPkg::cpuCtrlT ctrl,
  input  cpuDatapathPkg::dataT    writeData,
  input  logic [1:0]              buttons,
  input  cpuDatapathPkg::dataT    random,
  output cpuDatapathPkg::dataT    operandA,
  output cpuDatapathPkg::dataT    operandB,
  output cpuDatapathPkg::dataT    portOut
);

  import cpuIsaPkg::*;
  import cpuDatapathPkg::*;

  dataT     regs [16];
  regIndexT writeAddress;
  logic     writeAllowed;
  logic     portInRead;

  // write target: imm register for li, else regA or the result register
  assign writeAddress = ctrl.writeImmediate ? regImm :
                        (ctrl.writeSelect == wsRegA) ? instruction.regA : regResult;

  // zero, one and the button latch cannot be written by software
  assign writeAllowed = ctrl.writeEnable && (writeAddress != regZero) &&
                        (writeAddress != regOne) && (writeAddress != regPortIn);

  // either operand field naming the button latch counts as a read
  assign portInRead = (instruction.regA == regPortIn) || (instruction.regB == regPortIn);

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
      regs[regOne] <= dataT'(1);
    end else begin
      if (writeAllowed) begin
        regs[writeAddress] <= writeData;
      end
      // random register overrides any software write
      regs[regRand] <= random;
      // bit 1 is checked last so it wins
      if (buttons[0]) regs[regPortIn] <= dataT'(1);
      if (buttons[1]) regs[regPortIn] <= dataT'(2);
      // clear on read beats a new button pulse
      if (portInRead) regs[regPortIn] <= '0;
    end
  end

  // asynchronous read ports
  assign operandA = regs[instruction.regA];
  assign operandB = regs[instruction.regB];
  assign portOut  = regs[regPortOut];

endmodule

`default_nettype wire

// ==== source/alu.sv ====
// alu with combinational result and the registered compare flag used by branches
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic                 clk,
  input  logic                 reset,
  input  cpuIsaPkg::opcodeE    opcode,
  input  cpuDatapathPkg::dataT operandA,
  input  cpuDatapathPkg::dataT operandB,
  output cpuDatapathPkg::dataT result,
  output logic                 set
);

  import cpuIsaPkg::*;

  ////////////////////
  // result path
  ////////////////////

  always_comb begin
    unique case (opcode)
      opMov:          result = operandB;
      opAnd:          result = operandA & operandB;
      opOr:           result = operandA | operandB;
      opXor:          result = operandA ^ operandB;
      opShift:        result = operandA << operandB;
      opAdd, opAdds:  result = operandA + operandB;
      opSub, opSubs:  result = operandA - operandB;
      // li, compares, branches and delay produce nothing
      default:        result = '0;
    endcase
  end

  ////////////////////
  // compare flag
  ////////////////////

  // flag holds its value through every other opcode
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      set <= 1'b0;
    end else if (opcode == opSlt) begin
      set <= operandA < operandB;
    end else if (opcode == opEq) begin
      set <= operandA == operandB;
    end
  end

endmodule

`default_nettype wire

// ==== source/programCounter.sv ====
// program counter with jump load and the stall counter behind the delay instruction
`timescale 1ns/1ps
`default_nettype none

module programCounter (
  input  logic                    clk,
  input  logic                    reset,
  input  cpuDatapathPkg::cpuCtrlT ctrl,
  input  cpuDatapathPkg::dataT    immediate,
  output cpuDatapathPkg::pcT      pc
);

  import cpuDatapathPkg::*;

  delayCountT delayCount;
  delayCountT delayTarget;
  logic       delayPending;

  // operand scaled into delay cycles
  assign delayTarget = delayCountT'(immediate) << delayShift;

  // stall until the counter reaches the target
  assign delayPending = ctrl.pcDelay && (delayCount != delayTarget);

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      pc <= '0;
    end else if (ctrl.pcJump) begin
      pc <= immediate;
    end else if (!delayPending) begin
      pc <= pc + pcT'(1);
    end
  end

  // count up while the delay is presented, wrap to 0 on release
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      delayCount <= '0;
    end else if (ctrl.pcDelay) begin
      if (delayPending) begin
        delayCount <= delayCount + delayCountT'(1);
      end else begin
        delayCount <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/cpuCore.sv ====
// top of the 8-bit core, fetches from an external program memory and drives portOut
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
  input  logic                   clk,
  input  logic                   reset,
  input  cpuIsaPkg::instructionT instruction,
  input  logic [1:0]             buttons,
  input  cpuDatapathPkg::dataT   random,
  output cpuDatapathPkg::pcT     programCounter,
  output cpuDatapathPkg::dataT   portOut
);

  import cpuDatapathPkg::*;

  cpuCtrlT ctrl;
  logic    set;
  dataT    operandA;
  dataT    operandB;
  dataT    result;
  dataT    immediate;
  dataT    writeData;

  // both register fields form the immediate
  assign immediate = {instruction.regA, instruction.regB};

  ////////////////////
  // control
  ////////////////////

  cpuDecoder u_decoder (
    .instruction (instruction),
    .set         (set),
    .ctrl        (ctrl)
  );

  programCounter u_programCounter (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .immediate (immediate),
    .pc        (programCounter)
  );

  ////////////////////
  // datapath
  ////////////////////

  registerFile u_registerFile (
    .clk         (clk),
    .reset       (reset),
    .instruction (instruction),
    .ctrl        (ctrl),
    .writeData   (writeData),
    .buttons     (buttons),
    .random      (random),
    .operandA    (operandA),
    .operandB    (operandB),
    .portOut     (portOut)
  );

  alu u_alu (
    .clk      (clk),
    .reset    (reset),
    .opcode   (instruction.opcode),
    .operandA (operandA),
    .operandB (operandB),
    .result   (result),
    .set      (set)
  );

  // writeback select, li takes the immediate
  assign writeData = ctrl.writeImmediate ? immediate : result;

endmodule

`default_nettype wire

// ==== bench/clockGen.sv ====
// clock and reset source for the cpuCore testbench, 10 ns period, reset low for 8 cycles
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // release just after a rising edge, same as the other inputs
  initial begin
    reset = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1 reset = 1'b1;
  end

endmodule

`default_nettype wire

// ==== bench/cpuCore_assertions.sv ====
// checker bound into cpuCore, watches reset values, register one and program counter steps
`timescale 1ns/1ps
`default_nettype none

module cpuCoreAssertions (
  input logic                   clk,
  input logic                   reset,
  input cpuIsaPkg::instructionT instruction,
  input cpuDatapathPkg::dataT   immediate,
  input cpuDatapathPkg::dataT   operandA,
  input cpuDatapathPkg::dataT   operandB,
  input cpuDatapathPkg::pcT     programCounter,
  input cpuDatapathPkg::dataT   portOut
);

  import cpuIsaPkg::*;
  import cpuDatapathPkg::*;

  // failures so far, picked up by the testbench at the end
  int failCount = 0;

  // second edge in reset, the async clear has settled by then
  resetClears: assert property (
    @(posedge clk) !reset ##1 !reset |-> programCounter == '0 && portOut == '0
  ) else begin
    $error("programCounter or portOut not zero while in reset");
    failCount++;
  end

  // register one reads as 1 through either operand port
  oneOnPortA: assert property (
    @(posedge clk) disable iff (!reset) instruction.regA == regOne |-> operandA == dataT'(1)
  ) else begin
    $error("register one read as %h on operand A", operandA);
    failCount++;
  end

  oneOnPortB: assert property (
    @(posedge clk) disable iff (!reset) instruction.regB == regOne |-> operandB == dataT'(1)
  ) else begin
    $error("register one read as %h on operand B", operandB);
    failCount++;
  end

  // next pc is pc+1, the jump target, or the same pc under a delay
  pcStep: assert property (
    @(posedge clk) disable iff (!reset) $past(reset) |->
      programCounter == pcT'($past(programCounter) + 1'b1) ||
      programCounter == $past(immediate) ||
      (programCounter == $past(programCounter) && $past(instruction.opcode) == opDelay)
  ) else begin
    $error("programCounter stepped from %h to %h", $past(programCounter), programCounter);
    failCount++;
  end

endmodule

bind cpuCore cpuCoreAssertions u_assertions (
  .clk            (clk),
  .reset          (reset),
  .instruction    (instruction),
  .immediate      (immediate),
  .operandA       (operandA),
  .operandB       (operandB),
  .programCounter (programCounter),
  .portOut        (portOut)
);

`default_nettype wire

// ==== bench/cpuCoreTb.sv ====
// testbench top for cpuCore, serves the program memory from the stimulus file and checks portOut
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

  import cpuIsaPkg::*;
  import cpuDatapathPkg::*;

  // stimulus file layout
  localparam int progWords     = 64;
  localparam int eventBase     = 64;
  localparam int expectBase    = 80;
  localparam int stimWords     = 128;
  localparam int timeoutCycles = 500;
  localparam logic [19:0] endMark = 20'hfffff;

  logic        clk;
  logic        reset;
  instructionT instruction;
  logic [1:0]  buttons;
  dataT        random;
  pcT          programCounter;
  dataT        portOut;

  logic [19:0] stim [stimWords];
  logic [31:0] lcgState;
  // [0] is on the input now, [2] went in two cycles back
  dataT        randomHistory [3];
  int          cycleCount;
  int          errorCount;
  int          checkCount;

  clockGen u_clockGen (
    .clk   (clk),
    .reset (reset)
  );

  cpuCore u_dut (
    .clk            (clk),
    .reset          (reset),
    .instruction    (instruction),
    .buttons        (buttons),
    .random         (random),
    .programCounter (programCounter),
    .portOut        (portOut)
  );

  // next LCG state, the top byte is the random input
  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // button pulses listed for one execution cycle
  function automatic logic [1:0] buttonsAt(input int cycle);
    logic [1:0] pulse;
    pulse = 2'b00;
    for (int i = eventBase; i < expectBase; i++) begin
      if (stim[i] != endMark && int'(stim[i][19:4]) == cycle) begin
        pulse[stim[i][0]] = 1'b1;
      end
    end
    return pulse;
  endfunction

  ////////////////////
  // program memory and input drive
  ////////////////////

  always @(posedge clk) begin
    // cycle n is the n-th edge with reset released
    if (reset) begin
      cycleCount++;
    end
    #1;
    instruction = instructionT'(stim[int'(programCounter) % progWords][11:0]);
    lcgState = lcgNext(lcgState);
    randomHistory[2] = randomHistory[1];
    randomHistory[1] = randomHistory[0];
    randomHistory[0] = lcgState[31:24];
    random = lcgState[31:24];
    buttons = buttonsAt(cycleCount);
  end

  ////////////////////
  // portOut checking
  ////////////////////

  initial begin
    logic [19:0] entry;
    dataT        lastPort;
    dataT        expected;
    int          gap;
    int          waited;
    int          assertFails;
    logic        timedOut;

    for (int i = 0; i < stimWords; i++) begin
      stim[i] = endMark;
    end
    $readmemh("bench/cpuCore_stimulus.mem", stim);
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    lcgState = 32'h7aaf_6919;
    random = lcgState[31:24];
    randomHistory[0] = random;
    randomHistory[1] = random;
    randomHistory[2] = random;
    buttons = 2'b00;
    instruction = instructionT'(stim[0][11:0]);

    waited = 0;
    while (reset !== 1'b1 && waited < timeoutCycles) begin
      @(negedge clk);
      waited++;
    end
    assert (reset === 1'b1) else begin
      errorCount++;
      $display("reset was never released");
    end
    lastPort = portOut;

    for (int e = expectBase; e < stimWords && reset === 1'b1; e++) begin
      entry = stim[e];
      if (entry == endMark) begin
        break;
      end
      gap = int'(entry[19:12]);
      waited = 0;
      // wait for a change, or for exactly the gap when the entry has one
      do begin
        @(negedge clk);
        waited++;
        // with a gap, portOut holds until the last cycle of it
        if (gap != 0 && waited < gap) begin
          assert (portOut == lastPort) else begin
            errorCount++;
            $display("Fail at %0t ns: portOut expected %h, got %h", $time, lastPort, portOut);
          end
        end
      end while (waited < timeoutCycles &&
                 ((gap != 0) ? (waited < gap) : (portOut == lastPort)));
      timedOut = (portOut == lastPort) && (gap == 0);
      assert (!timedOut) else begin
        errorCount++;
        $display("portOut did not change within %0d cycles, stopping", timeoutCycles);
      end
      if (timedOut) begin
        break;
      end
      expected = (entry[11:8] == 4'h1) ? randomHistory[2] : entry[7:0];
      checkCount++;
      assert (portOut == expected) else begin
        errorCount++;
        $display("Fail at %0t ns: portOut expected %h, got %h", $time, expected, portOut);
      end
      lastPort = portOut;
    end

    // a few more cycles for the bound checker
    repeat (4) @(negedge clk);
    assertFails = u_dut.u_assertions.failCount;
    $display("checks %0d, value errors %0d, assertion failures %0d",
             checkCount, errorCount, assertFails);
    if (errorCount == 0 && assertFails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
source/cpuIsaPkg.sv
source/cpuDatapathPkg.sv
source/cpuDecoder.sv
source/registerFile.sv
source/alu.sv
source/programCounter.sv
source/cpuCore.sv
bench/clockGen.sv
bench/cpuCore_assertions.sv
bench/cpuCoreTb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - target: rtl
    files:
      - source/cpuIsaPkg.sv
      - source/cpuDatapathPkg.sv
      - source/cpuDecoder.sv
      - source/registerFile.sv
      - source/alu.sv
      - source/programCounter.sv
      - source/cpuCore.sv
  - target: bench
    files:
      - bench/clockGen.sv
      - bench/cpuCore_assertions.sv
      - bench/cpuCoreTb.sv

// ==== bench/cpuCore_stimulus.mem ====
// 000-03f program words: opcode regA regB
// 040-04f button events: cycle (16 bits) then bit; 050-07f expected portOut: gap kind value
@00
// li 35, copy to r7, li 1c, then add sub and or xor shift, each result sent to portOut
935 075 91c 475 046 675 046 175
046 275 046 375 046 871 046
// writes to r0 and r1 are dropped, then both are read out
007 017 040 041
// slt set, bns falls through to a1, eq clear, bos falls through, bns jumps to b3
a17 d30 9a1 045 b71 c30 d1d 9ee 045 000 9b3 045
// eq set, bos jumps over ee to c4
b11 c23 9ee 045 9c4 045
// random byte to portOut, delay 3, then r0 to portOut
043 f03 040 e30
@30
// poll the button latch twice, show each value, then one more read
072 b70 c30 047 072 b70 c34 047 042 e39
@40
// bit 0 at cycle 56, bit 1 at cycle 72, both on the bos of the poll loop
00380 00481
@50
// gap 00 means unchecked, kind 1 means the random byte from two cycles back
00051 00019 00014 0003d 00029 0006a
00000 00001
000a1 000b3 000c4
01100 0e000
00001 00002 00000
